//--- dbg_bus_module.f
+incdir+rtl
rtl/dbg_cmd_pkg.sv
rtl/dbg_bus_pkg.sv
rtl/dbg_cmd_decode.sv
rtl/dbg_burst_fsm.sv
rtl/dbg_crc32.sv
rtl/dbg_result_shift.sv
rtl/dbg_bus_module.sv
dv/dbg_bus_module_tb.sv

//--- dv/dbg_bus_module_tb.sv
// Testbench for the JTAG burst debug module
// Clock, reset, TAP stimulus tasks and a byte-wide bus memory model
// Reference CRC and word extraction, value checker and cycle timeout
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_bus_module_tb
  import dbg_cmd_pkg::*;
  import dbg_bus_pkg::*;
();

  // All bursts together take about 450 cycles
  localparam int          TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] SEED           = 32'hf49e;

  logic                 tck_i = 1'b0;
  logic                 rst_i;
  logic                 capture_dr_i, shift_dr_i, update_dr_i;
  logic                 module_select_i;
  logic                 tdi_i;
  logic [`DBG_DR_W-1:0] data_register_i;   // TAP data register shifting right
  logic                 module_tdo_o;
  logic                 top_inhibit_o;
  dbg_bus_req_t         bus_req_o;
  dbg_bus_rsp_t         bus_rsp_i;

  logic [7:0]  mem [0:1023];               // 256 words in byte lanes
  logic [31:0] exp_addr [$];               // Expected bus writes in order
  logic [31:0] exp_word [$];
  logic [31:0] burst_words [$];            // Words of the last write burst
  logic [31:0] data_seed;
  logic [31:0] delay_seed;
  int          exp_size = 0;               // Word bytes of the running burst
  int          cycle_cnt = 0;

  dbg_bus_module uut (
    .tck_i, .rst_i, .capture_dr_i, .shift_dr_i, .update_dr_i, .module_select_i,
    .tdi_i, .data_register_i, .module_tdo_o, .top_inhibit_o, .bus_req_o, .bus_rsp_i
  );

  always #2 tck_i = ~tck_i;                // 4 ns period

  //////////////////////////////////////////////////////////////////////
  // Reference functions
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reflected CRC-32 over data taken LSB first with no final inversion
  function automatic logic [31:0] crc_ref(input logic [31:0] crc, input logic [31:0] data,
                                          input int nbits);
    logic [31:0] c;
    int          k;
    c = crc;
    for (k = 0; k < nbits; k++) begin
      if (c[0] ^ data[k]) begin
        c = (c >> 1) ^ `DBG_CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  // Narrow write words sit in the top bits of wdata
  function automatic logic [31:0] extract_word(input logic [31:0] wdata,
                                               input logic [2:0] size_bytes);
    return wdata >> (32 - 8 * size_bytes);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks and run control
  //////////////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  always @(posedge tck_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus memory model answering one access at a time after 1 to 3 cycles
  //////////////////////////////////////////////////////////////////////
  initial begin : bus_model
    dbg_bus_req_t req;
    logic [31:0]  word;
    logic [9:0]   ma;
    int           delay, b, i;
    bus_rsp_i  = '0;
    delay_seed = xorshift(SEED);
    for (i = 0; i < 1024; i++) begin
      mem[i] = 8'(i) ^ {i[9:8], 6'h2b};    // Fill depends on every address bit
    end
    forever begin
      @(negedge tck_i);                    // Request is stable mid cycle
      if (bus_req_o.strobe) begin
        req        = bus_req_o;
        delay_seed = xorshift(delay_seed);
        delay      = 1 + int'(delay_seed % 32'd3);
        word       = '0;
        check_value("bus access size", 32'(req.size_bytes), 32'(exp_size));
        if (req.we) begin
          word = extract_word(req.wdata, req.size_bytes);
          if (exp_addr.size() == 0) begin
            $display("Bus write at %0t ns that no burst asked for", $time);
            abort_run();
          end
          check_value("write address", req.addr, exp_addr.pop_front());
          check_value("write word", word, exp_word.pop_front());
          for (b = 0; b < int'(req.size_bytes); b++) begin
            ma      = req.addr[9:0] + 10'(b);
            mem[ma] = word[8*b +: 8];      // Little endian lanes
          end
          word = '0;
        end else begin
          for (b = 0; b < int'(req.size_bytes); b++) begin
            ma             = req.addr[9:0] + 10'(b);
            word[8*b +: 8] = mem[ma];      // Right-aligned read data
          end
        end
        repeat (delay) @(posedge tck_i);
        #1;
        bus_rsp_i.ack   = 1'b1;
        bus_rsp_i.rdata = word;
        @(posedge tck_i);
        #1;
        bus_rsp_i = '0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // TAP stimulus tasks start and end 1 ns after a rising edge
  //////////////////////////////////////////////////////////////////////
  task automatic pulse_update(input logic [`DBG_DR_W-1:0] value);
    shift_dr_i      = 1'b0;
    data_register_i = value;
    update_dr_i     = 1'b1;
    @(posedge tck_i);
    #1;
    update_dr_i = 1'b0;
  endtask

  // Select-DR cycle, then capture loads zeros
  task automatic capture_zeros();
    @(posedge tck_i);
    #1;
    capture_dr_i = 1'b1;
    @(posedge tck_i);
    #1;
    capture_dr_i    = 1'b0;
    data_register_i = '0;
  endtask

  task automatic shift_bit(input logic bit_in, output logic bit_out);
    tdi_i      = bit_in;
    shift_dr_i = 1'b1;
    @(negedge tck_i);
    bit_out = module_tdo_o;
    check_value("inhibit during shift", 32'(top_inhibit_o), 32'd1);
    @(posedge tck_i);
    #1;
    data_register_i = {bit_in, data_register_i[`DBG_DR_W-1:1]};
  endtask

  task automatic expect_idle();
    @(negedge tck_i);
    check_value("inhibit in idle", 32'(top_inhibit_o), 32'd0);
    check_value("bus strobe in idle", 32'(bus_req_o.strobe), 32'd0);
    @(posedge tck_i);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bursts
  //////////////////////////////////////////////////////////////////////
  task automatic write_burst(input logic [3:0] op, input int size, input logic [31:0] addr,
                             input int n, input logic flip_crc);
    logic [31:0] word, crc, mask;
    logic        tdo_bit;
    int          i, k;
    mask = (size == 4) ? 32'hffff_ffff : (32'h1 << (8 * size)) - 32'h1;
    crc  = `DBG_CRC_INIT;
    burst_words.delete();
    exp_size = size;
    pulse_update({1'b0, op, addr, 16'(n)});
    capture_zeros();
    shift_bit(1'b1, tdo_bit);              // Start bit
    for (i = 0; i < n; i++) begin
      data_seed = xorshift(data_seed);
      word      = data_seed & mask;
      burst_words.push_back(word);
      exp_addr.push_back(addr + 32'(size * i));
      exp_word.push_back(word);
      crc = crc_ref(crc, word, 8 * size);
      for (k = 0; k < 8 * size; k++) begin
        shift_bit(word[k], tdo_bit);
      end
    end
    if (flip_crc) begin
      crc[5] = ~crc[5];                    // One wrong bit must fail the compare
    end
    for (k = 0; k < 32; k++) begin
      shift_bit(crc[k], tdo_bit);
    end
    shift_bit(1'b0, tdo_bit);              // Match bit comes out here
    check_value("CRC match bit", 32'(tdo_bit), flip_crc ? 32'd0 : 32'd1);
    pulse_update(data_register_i);
    if (exp_addr.size() != 0) begin
      $display("Write burst ended with %0d bus writes missing", exp_addr.size());
      abort_run();
    end
    expect_idle();
  endtask

  // Reads back the halfwords of the last write burst
  task automatic read_halfwords(input logic [31:0] addr, input int n);
    logic [31:0] got, exp, crc;
    logic        tdo_bit;
    int          i, k, tries;
    crc      = `DBG_CRC_INIT;
    tries    = 0;
    exp_size = 2;
    pulse_update({1'b0, BREAD16, addr, 16'(n)});
    capture_zeros();
    do begin
      shift_bit(1'b0, tdo_bit);            // Status repeats until data is held
      tries++;
    end while (!tdo_bit && tries < 8);
    check_value("read status bit", 32'(tdo_bit), 32'd1);
    for (i = 0; i < n; i++) begin
      exp = burst_words[i / 2] >> (16 * (i % 2));
      exp = exp & 32'h0000_ffff;
      got = '0;
      for (k = 0; k < 16; k++) begin
        shift_bit(1'b0, tdo_bit);
        got[k] = tdo_bit;                  // LSB first
      end
      check_value($sformatf("read halfword %0d", i), got, exp);
      crc = crc_ref(crc, exp, 16);
    end
    got = '0;
    for (k = 0; k < 32; k++) begin
      shift_bit(1'b0, tdo_bit);
      got[k] = tdo_bit;
    end
    check_value("read CRC", got, crc);
    pulse_update(data_register_i);
    expect_idle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    rst_i           = 1'b1;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b0;
    tdi_i           = 1'b0;
    data_register_i = '0;
    data_seed       = SEED;
    repeat (2) @(posedge tck_i);
    #1;
    rst_i           = 1'b0;
    module_select_i = 1'b1;
    @(negedge tck_i);
    check_value("TDO after reset", 32'(module_tdo_o), 32'd0);
    expect_idle();

    write_burst(BWRITE32, 4, 32'h0000_0040, 4, 1'b0);
    read_halfwords(32'h0000_0040, 8);     // Same region read as halfwords
    write_burst(BWRITE8, 1, 32'h0000_0081, 6, 1'b1);

    $display("Test passed");
    $finish;
  end

endmodule

//--- rtl/dbg_burst_fsm.sv
// Burst control FSM, high-speed flow only
// Bit counter, bus ready flag and read data holding register
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_burst_fsm
  import dbg_cmd_pkg::*;
  import dbg_bus_pkg::*;
(
  input  logic                   tck_i,
  input  logic                   rst_i,
  input  logic                   capture_dr_i,
  input  logic                   shift_dr_i,
  input  logic                   update_dr_i,
  input  logic                   module_select_i,
  input  logic                   tdi_i,
  input  logic [`DBG_DR_W-1:0]   data_register_i,
  input  logic                   burst_cmd_i,
  input  dbg_cmd_t               cmd_i,
  input  logic                   cnt_zero_i,
  input  logic                   cnt_last_i,
  input  dbg_bus_rsp_t           bus_rsp_i,
  output dbg_ctrl_t              ctrl_o,
  output dbg_bus_req_t           bus_req_o,
  output logic [`DBG_DATA_W-1:0] rdata_o,
  output logic                   ready_o,
  output logic                   top_inhibit_o
);

  localparam logic [`DBG_BITCNT_W-1:0] CRC_BITS = `DBG_DATA_W;

  typedef enum logic [3:0] {
    S_IDLE, S_RBEGIN, S_RREADY, S_RSTATUS, S_RBURST, S_RCRC,
    S_WREADY, S_WWAIT, S_WBURST, S_WCRC, S_WMATCH
  } state_e;

  state_e                   state_q, state_d;
  logic [`DBG_BITCNT_W-1:0] bit_cnt_q;
  logic                     bit_clr, bit_inc;
  logic                     ready_q;            // No bus access in flight
  logic [`DBG_DATA_W-1:0]   rdata_q;
  logic                     strobe;
  logic                     word_end;

  assign word_end = (bit_cnt_q == cmd_i.last_bit);  // Last bit of word on this edge

  //////////////////////////////////////////////////////////////////////
  // Next state and control strobes
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d        = state_q;
    ctrl_o         = '0;
    ctrl_o.tdo_sel = 2'd1;
    strobe         = 1'b0;
    bit_clr        = 1'b0;
    bit_inc        = 1'b0;
    top_inhibit_o  = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (update_dr_i && burst_cmd_i) begin
          ctrl_o.cmd_ld  = 1'b1;
          ctrl_o.crc_clr = 1'b1;
          bit_clr        = 1'b1;
          state_d        = data_register_i[`DBG_OP_LSB+2] ? S_RBEGIN : S_WREADY;
        end
      end
      S_RBEGIN: begin
        if (cnt_zero_i) begin
          state_d = S_IDLE;              // Empty burst
        end else begin
          strobe          = 1'b1;        // First read ahead of the debugger
          ctrl_o.addr_inc = 1'b1;
          state_d         = S_RREADY;
        end
      end
      S_RREADY: begin
        if (module_select_i && capture_dr_i) begin
          state_d = S_RSTATUS;
        end
      end
      S_RSTATUS: begin
        top_inhibit_o  = 1'b1;
        ctrl_o.tdo_sel = 2'd0;           // Status bit stays 0 until data arrives
        if (update_dr_i) begin
          state_d = S_IDLE;
        end else if (shift_dr_i && ready_q) begin
          ctrl_o.out_ld  = 1'b1;
          ctrl_o.cnt_dec = 1'b1;
          bit_clr        = 1'b1;
          if (!cnt_last_i) begin
            strobe          = 1'b1;
            ctrl_o.addr_inc = 1'b1;
          end
          state_d = S_RBURST;
        end
      end
      S_RBURST: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = S_IDLE;
        end else if (shift_dr_i) begin
          ctrl_o.out_shift = 1'b1;
          ctrl_o.crc_en    = 1'b1;       // CRC over outgoing LSB
          bit_inc          = 1'b1;
          if (word_end && cnt_zero_i) begin
            state_d = S_RCRC;
          end else if (word_end) begin
            ctrl_o.out_ld  = 1'b1;       // Next word is already held
            ctrl_o.cnt_dec = 1'b1;
            bit_clr        = 1'b1;
            if (!cnt_last_i) begin
              strobe          = 1'b1;
              ctrl_o.addr_inc = 1'b1;
            end
          end
        end
      end
      S_RCRC: begin
        top_inhibit_o  = 1'b1;
        ctrl_o.tdo_sel = 2'd3;
        if (update_dr_i) begin
          state_d = S_IDLE;              // Also the recovery state
        end else if (shift_dr_i) begin
          ctrl_o.crc_shift = 1'b1;
        end
      end
      S_WREADY: begin
        if (cnt_zero_i) begin
          state_d = S_IDLE;
        end else if (module_select_i && capture_dr_i) begin
          state_d = S_WWAIT;
        end
      end
      S_WWAIT: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = S_IDLE;
        end else if (module_select_i && shift_dr_i && data_register_i[`DBG_CMD_BIT]) begin
          // Start bit is in, tdi already holds data bit 0
          ctrl_o.crc_en     = 1'b1;
          ctrl_o.crc_in_tdi = 1'b1;
          bit_inc           = 1'b1;
          state_d           = S_WBURST;
        end
      end
      S_WBURST: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = S_IDLE;
        end else if (shift_dr_i) begin
          ctrl_o.crc_en     = 1'b1;
          ctrl_o.crc_in_tdi = 1'b1;
          bit_inc           = 1'b1;
          if (word_end) begin
            strobe          = 1'b1;      // Whole word sits in the window
            ctrl_o.addr_inc = 1'b1;
            ctrl_o.cnt_dec  = 1'b1;
            bit_clr         = 1'b1;
            if (cnt_last_i) begin
              state_d = S_WCRC;
            end
          end
        end
      end
      S_WCRC: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = S_IDLE;
        end else if (bit_cnt_q == CRC_BITS) begin
          ctrl_o.tdo_sel = 2'd2;         // Match bit goes out now
          state_d        = S_WMATCH;
        end else if (shift_dr_i) begin
          bit_inc = 1'b1;
        end
      end
      S_WMATCH: begin
        top_inhibit_o  = 1'b1;
        ctrl_o.tdo_sel = 2'd2;
        if (update_dr_i) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= S_IDLE;
      bit_cnt_q <= '0;
      ready_q   <= 1'b1;
    end else begin
      state_q <= state_d;
      if (bit_clr) begin
        bit_cnt_q <= '0;
      end else if (bit_inc) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      if (strobe) begin
        ready_q <= 1'b0;
      end else if (bus_rsp_i.ack) begin
        ready_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge tck_i) begin
    if (bus_rsp_i.ack) begin
      rdata_q <= bus_rsp_i.rdata;  // Held until the output load
    end
  end

  assign rdata_o = rdata_q;
  assign ready_o = ready_q;

  always_comb begin
    bus_req_o.strobe     = strobe;
    bus_req_o.we         = !cmd_i.rd;
    bus_req_o.size_bytes = cmd_i.size_bytes;
    bus_req_o.addr       = cmd_i.addr;
    bus_req_o.wdata      = {tdi_i, data_register_i[`DBG_DR_W-1 -: `DBG_DATA_W-1]};
  end

  // Reads run a word ahead, the bus must answer within one word time
  a_strobe_ready: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_req_o.strobe |-> ready_q);

  // Update in any data phase returns to idle
  a_inhibit_idle: assert property (@(posedge tck_i) disable iff (rst_i)
    (top_inhibit_o && update_dr_i) |=> !top_inhibit_o);

endmodule

//--- rtl/dbg_bus_module.sv
// JTAG burst debug module, top level
// Decode, burst FSM, CRC and result stages
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_bus_module
  import dbg_cmd_pkg::*;
  import dbg_bus_pkg::*;
(
  input  logic                 tck_i,
  input  logic                 rst_i,
  input  logic                 capture_dr_i,
  input  logic                 shift_dr_i,
  input  logic                 update_dr_i,
  input  logic                 module_select_i,
  input  logic                 tdi_i,
  input  logic [`DBG_DR_W-1:0] data_register_i,
  output logic                 module_tdo_o,
  output logic                 top_inhibit_o,
  output dbg_bus_req_t         bus_req_o,
  input  dbg_bus_rsp_t         bus_rsp_i
);

  dbg_ctrl_t              ctrl;
  dbg_cmd_t               cmd;
  logic                   burst_cmd, cnt_zero, cnt_last;
  logic [`DBG_DATA_W-1:0] rdata;
  logic                   ready, out_lsb, crc_bit, crc_match;

  dbg_cmd_decode u_decode (
    .tck_i, .rst_i, .data_register_i, .module_select_i,
    .ctrl_i(ctrl), .burst_cmd_o(burst_cmd), .cmd_o(cmd),
    .cnt_zero_o(cnt_zero), .cnt_last_o(cnt_last)
  );

  dbg_burst_fsm u_fsm (
    .tck_i, .rst_i, .capture_dr_i, .shift_dr_i, .update_dr_i, .module_select_i,
    .tdi_i, .data_register_i, .burst_cmd_i(burst_cmd), .cmd_i(cmd),
    .cnt_zero_i(cnt_zero), .cnt_last_i(cnt_last), .bus_rsp_i,
    .ctrl_o(ctrl), .bus_req_o, .rdata_o(rdata), .ready_o(ready), .top_inhibit_o
  );

  dbg_crc32 u_crc (
    .tck_i, .rst_i, .tdi_i, .out_lsb_i(out_lsb), .data_register_i,
    .ctrl_i(ctrl), .crc_bit_o(crc_bit), .crc_match_o(crc_match)
  );

  dbg_result_shift u_result (
    .tck_i, .rst_i, .ctrl_i(ctrl), .rdata_i(rdata), .ready_i(ready),
    .crc_bit_i(crc_bit), .crc_match_i(crc_match),
    .out_lsb_o(out_lsb), .module_tdo_o
  );

endmodule

//--- rtl/dbg_bus_pkg.sv
// System bus request and response
`include "dbg_params.svh"

package dbg_bus_pkg;

  typedef struct packed {
    logic                   strobe;      // One cycle per access
    logic                   we;
    logic [2:0]             size_bytes;
    logic [`DBG_ADDR_W-1:0] addr;
    logic [`DBG_DATA_W-1:0] wdata;       // Narrow words in the top bits
  } dbg_bus_req_t;

  typedef struct packed {
    logic                   ack;
    logic [`DBG_DATA_W-1:0] rdata;       // Right-aligned
  } dbg_bus_rsp_t;

endpackage

//--- rtl/dbg_cmd_decode.sv
// Burst command decode
// Opcode, address counter and word counter
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_cmd_decode
  import dbg_cmd_pkg::*;
(
  input  logic                 tck_i,
  input  logic                 rst_i,
  input  logic [`DBG_DR_W-1:0] data_register_i,
  input  logic                 module_select_i,
  input  dbg_ctrl_t            ctrl_i,
  output logic                 burst_cmd_o,
  output dbg_cmd_t             cmd_o,
  output logic                 cnt_zero_o,
  output logic                 cnt_last_o
);

  logic [3:0]             op_in;
  dbg_op_e                op_q;
  logic [`DBG_ADDR_W-1:0] addr_q;
  logic [`DBG_CNT_W-1:0]  cnt_q;

  assign op_in = data_register_i[`DBG_OP_LSB +: 4];

  // Module command with a write or read burst opcode
  assign burst_cmd_o = module_select_i && !data_register_i[`DBG_CMD_BIT] &&
                       !op_in[3] && (op_in[1:0] != 2'b00);

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      op_q   <= BWRITE8;
      addr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (ctrl_i.cmd_ld) begin
        op_q   <= dbg_op_e'(op_in);
        addr_q <= data_register_i[`DBG_ADDR_LSB +: `DBG_ADDR_W];
        cnt_q  <= data_register_i[`DBG_CNT_W-1:0];
      end else begin
        if (ctrl_i.addr_inc) begin
          addr_q <= addr_q + `DBG_ADDR_W'(cmd_o.size_bytes);  // Step by word size
        end
        if (ctrl_i.cnt_dec) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  always_comb begin
    cmd_o.rd   = op_q[2];
    cmd_o.addr = addr_q;
    case (op_q)
      BWRITE8, BREAD8: begin
        cmd_o.size_bytes = 3'd1;
        cmd_o.last_bit   = 6'd7;
      end
      BWRITE16, BREAD16: begin
        cmd_o.size_bytes = 3'd2;
        cmd_o.last_bit   = 6'd15;
      end
      default: begin
        cmd_o.size_bytes = 3'd4;
        cmd_o.last_bit   = 6'd31;
      end
    endcase
  end

  assign cnt_zero_o = (cnt_q == '0);
  assign cnt_last_o = (cnt_q == `DBG_CNT_W'(1));  // Zero after next decrement

  // FSM only loads on a decoded burst opcode
  a_op_legal: assert property (@(posedge tck_i) disable iff (rst_i)
    ctrl_i.cmd_ld |=> op_q inside {BWRITE8, BWRITE16, BWRITE32, BREAD8, BREAD16, BREAD32});

endmodule

//--- rtl/dbg_cmd_pkg.sv
// Burst opcode encoding
// Decoded command and FSM control strobes
`include "dbg_params.svh"

package dbg_cmd_pkg;

  typedef enum logic [3:0] {
    BWRITE8  = 4'h1,
    BWRITE16 = 4'h2,
    BWRITE32 = 4'h3,
    BREAD8   = 4'h5,   // Bit 2 marks a read
    BREAD16  = 4'h6,
    BREAD32  = 4'h7
  } dbg_op_e;

  typedef struct packed {
    logic                     rd;
    logic [2:0]               size_bytes;  // 1, 2 or 4
    logic [`DBG_BITCNT_W-1:0] last_bit;    // Word bits minus one
    logic [`DBG_ADDR_W-1:0]   addr;        // Next bus address
  } dbg_cmd_t;

  typedef struct packed {
    logic       cmd_ld;      // Latch opcode, address and count
    logic       addr_inc;
    logic       cnt_dec;
    logic       out_ld;      // Parallel load of read data
    logic       out_shift;
    logic       crc_clr;
    logic       crc_en;
    logic       crc_in_tdi;  // 1 = write data, 0 = read data
    logic       crc_shift;
    logic [1:0] tdo_sel;     // 0 ready, 1 data, 2 match, 3 CRC
  } dbg_ctrl_t;

endpackage

//--- rtl/dbg_crc32.sv
// Serial reflected CRC-32
// Doubles as its own output shift register, plus match compare
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_crc32
  import dbg_cmd_pkg::*;
(
  input  logic                 tck_i,
  input  logic                 rst_i,
  input  logic                 tdi_i,
  input  logic                 out_lsb_i,
  input  logic [`DBG_DR_W-1:0] data_register_i,
  input  dbg_ctrl_t            ctrl_i,
  output logic                 crc_bit_o,
  output logic                 crc_match_o
);

  logic [`DBG_DATA_W-1:0] crc_q;
  logic                   din;
  logic                   fb;

  assign din = ctrl_i.crc_in_tdi ? tdi_i : out_lsb_i;  // Write or read data
  assign fb  = din ^ crc_q[0];

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= `DBG_CRC_INIT;
    end else if (ctrl_i.crc_clr) begin
      crc_q <= `DBG_CRC_INIT;
    end else if (ctrl_i.crc_en) begin
      crc_q <= {1'b0, crc_q[`DBG_DATA_W-1:1]} ^ (fb ? `DBG_CRC_POLY : '0);
    end else if (ctrl_i.crc_shift) begin
      crc_q <= {1'b0, crc_q[`DBG_DATA_W-1:1]};     // Shift out LSB first
    end
  end

  assign crc_bit_o   = crc_q[0];
  assign crc_match_o = (crc_q == data_register_i[`DBG_WIN_LSB +: `DBG_DATA_W]);

endmodule

//--- rtl/dbg_params.svh
// Widths and field positions of the debug module data register
// CRC-32 polynomial and start value
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////
`define DBG_DR_W      53   // TAP data register
`define DBG_ADDR_W    32
`define DBG_DATA_W    32   // Bus data, also CRC width
`define DBG_CNT_W     16   // Word count of one burst
`define DBG_BITCNT_W  6    // Counts up to 32 CRC bits

// Reflected CRC-32, shifted LSB first
`define DBG_CRC_POLY  32'hEDB88320
`define DBG_CRC_INIT  32'hFFFFFFFF

//////////////////////////////////////////////////////////////////////
// Field positions in the data register
//////////////////////////////////////////////////////////////////////
`define DBG_CMD_BIT   52   // 1 selects a top level command
`define DBG_OP_LSB    48   // 4-bit opcode
`define DBG_ADDR_LSB  16   // Start address, count sits below it
`define DBG_WIN_LSB   21   // 32-bit CRC window after shift

`endif

//--- rtl/dbg_result_shift.sv
// Read data output shift register
// TDO source select
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_result_shift
  import dbg_cmd_pkg::*;
(
  input  logic                   tck_i,
  input  logic                   rst_i,
  input  dbg_ctrl_t              ctrl_i,
  input  logic [`DBG_DATA_W-1:0] rdata_i,
  input  logic                   ready_i,
  input  logic                   crc_bit_i,
  input  logic                   crc_match_i,
  output logic                   out_lsb_o,
  output logic                   module_tdo_o
);

  logic [`DBG_DATA_W-1:0] out_q;

  // Load wins over shift on a word boundary
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_q <= '0;
    end else if (ctrl_i.out_ld) begin
      out_q <= rdata_i;
    end else if (ctrl_i.out_shift) begin
      out_q <= {1'b0, out_q[`DBG_DATA_W-1:1]};
    end
  end

  assign out_lsb_o = out_q[0];  // Also feeds the read CRC

  always_comb begin
    case (ctrl_i.tdo_sel)
      2'd0:    module_tdo_o = ready_i;      // Status bit
      2'd1:    module_tdo_o = out_q[0];
      2'd2:    module_tdo_o = crc_match_i;
      default: module_tdo_o = crc_bit_i;
    endcase
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the debug module testbench with Verilator and run it
# The result is taken from the pass line in sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module dbg_bus_module_tb -f dbg_bus_module.f -o dbg_bus_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dbg_bus_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test passed$" sim.log; then
  echo "Simulation PASS"
  exit 0
fi
echo "Simulation FAIL"
exit 1
